//--- Makefile
# Verilator build and run for the secure subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_secure_subsystem
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(BUILD_DIR)

//--- design/axi_dw_upsizer.sv
// Single-beat 32-to-64-bit width converter from the narrow controller bus onto the wide AXI-style port
`timescale 1ns/100ps

module axi_dw_upsizer (
   input  logic                clk_i,
   input  logic                arst_n_i,
   // Narrow side
   input  logic                nb_valid_i,
   input  ss_pkg::narrow_req_t nb_req_i,
   output logic                nb_ready_o,
   output logic                rsp_valid_o,
   output ss_pkg::narrow_rsp_t rsp_o,
   input  logic                rsp_ready_i,
   // Wide side
   output ss_pkg::ax_chan_t    aw_o,
   output logic                aw_valid_o,
   input  logic                aw_ready_i,
   output ss_pkg::w_chan_t     w_o,
   output logic                w_valid_o,
   input  logic                w_ready_i,
   input  ss_pkg::b_chan_t     b_i,
   input  logic                b_valid_i,
   output logic                b_ready_o,
   output ss_pkg::ax_chan_t    ar_o,
   output logic                ar_valid_o,
   input  logic                ar_ready_i,
   input  ss_pkg::r_chan_t     r_i,
   input  logic                r_valid_i,
   output logic                r_ready_o
);

   import ss_pkg::*;

   localparam wide_strb_t StrbLower = wide_strb_t'(8'h0F);
   localparam wide_strb_t StrbUpper = wide_strb_t'(8'hF0);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ADDR,
      ST_WAIT_B,
      ST_WAIT_R,
      ST_RSP
   } state_e;

   state_e       state_q;
   state_e       state_d;
   logic         aw_valid_q;
   logic         w_valid_q;
   logic         ar_valid_q;
   logic         we_q;
   logic         lane_q;
   narrow_addr_t addr_q;
   narrow_data_t wdata_q;
   bus_id_t      id_q;
   narrow_rsp_t  rsp_q;
   logic         addr_done;

   // AW and W may be taken in either order
   assign addr_done = (!aw_valid_q || aw_ready_i) && (!w_valid_q || w_ready_i) &&
                      (!ar_valid_q || ar_ready_i);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:   if (nb_valid_i) state_d = ST_ADDR;
         ST_ADDR:   if (addr_done) state_d = we_q ? ST_WAIT_B : ST_WAIT_R;
         ST_WAIT_B: if (b_valid_i) state_d = ST_RSP;
         ST_WAIT_R: if (r_valid_i) state_d = ST_RSP;
         ST_RSP:    if (rsp_ready_i) state_d = ST_IDLE;
         default:   state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= ST_IDLE;
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         ar_valid_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_IDLE && nb_valid_i) begin
            aw_valid_q <= nb_req_i.we;
            w_valid_q  <= nb_req_i.we;
            ar_valid_q <= !nb_req_i.we;
         end else begin
            if (aw_ready_i) aw_valid_q <= 1'b0;
            if (w_ready_i) w_valid_q <= 1'b0;
            if (ar_ready_i) ar_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && nb_valid_i) begin
         we_q    <= nb_req_i.we;
         lane_q  <= nb_req_i.addr[2];
         addr_q  <= nb_req_i.addr;
         wdata_q <= nb_req_i.wdata;
         id_q    <= nb_req_i.id;
      end
      if (b_valid_i && b_ready_o) begin
         rsp_q.rdata <= '0;
         rsp_q.resp  <= b_i.resp;
      end
      if (r_valid_i && r_ready_o) begin
         // Pick the half that holds the addressed word
         rsp_q.rdata <= lane_q ? r_i.data[WideDataWidth-1 -: NarrowDataWidth]
                               : r_i.data[NarrowDataWidth-1:0];
         rsp_q.resp  <= r_i.resp;
      end
   end

   assign aw_o       = '{id: id_q, addr: addr_q};
   assign aw_valid_o = aw_valid_q;
   assign ar_o       = '{id: id_q, addr: addr_q};
   assign ar_valid_o = ar_valid_q;

   // Word copied to both lanes, strobe selects one
   assign w_o.data  = {(WideDataWidth / NarrowDataWidth){wdata_q}};
   assign w_o.strb  = lane_q ? StrbUpper : StrbLower;
   assign w_o.last  = 1'b1;
   assign w_valid_o = w_valid_q;

   assign b_ready_o   = (state_q == ST_WAIT_B);
   assign r_ready_o   = (state_q == ST_WAIT_R);
   assign nb_ready_o  = (state_q == ST_ADDR) && addr_done;
   assign rsp_valid_o = (state_q == ST_RSP);
   assign rsp_o       = rsp_q;

   a_b_id: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (b_valid_i && b_ready_o) |-> (b_i.id == id_q)
   ) else $error("axi_dw_upsizer: b_id does not match the issued id");

   // Single-beat reads only
   a_r_id: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (r_valid_i && r_ready_o) |-> (r_i.id == id_q && r_i.last)
   ) else $error("axi_dw_upsizer: r_id mismatch or r_last missing");

endmodule

//--- design/entropy_rng.sv
// Seeded LFSR random word source for the command controller that offers one word per take
`timescale 1ns/100ps

module entropy_rng #(
   parameter ss_pkg::narrow_data_t RngSeed = ss_pkg::LfsrSeedDefault
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic                 rng_take_i,
   output logic                 rng_valid_o,
   output ss_pkg::narrow_data_t rng_word_o
);

   import ss_pkg::*;

   narrow_data_t lfsr_q;
   narrow_data_t lfsr_next;
   logic         valid_q;

   // Shift right, fold taps in when a one drops out
   assign lfsr_next = (lfsr_q >> 1) ^ (lfsr_q[0] ? LfsrTaps : '0);

   // One refill cycle after every take
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lfsr_q  <= RngSeed;
         valid_q <= 1'b0;
      end else if (rng_take_i) begin
         lfsr_q  <= lfsr_next;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b1;
      end
   end

   assign rng_valid_o = valid_q;
   assign rng_word_o  = lfsr_q;

   // All-zero state would lock the generator
   a_lfsr_nonzero: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      lfsr_q != '0
   ) else $error("entropy_rng: LFSR reached the zero state");

   // Consumer takes only a word on offer
   a_take_when_valid: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      rng_take_i |-> rng_valid_o
   ) else $error("entropy_rng: take while no word is valid");

endmodule

//--- design/rot_cmd_ctrl.sv
// Root-of-trust command controller, turns four-phase host commands into single narrow bus transfers
`timescale 1ns/100ps

module rot_cmd_ctrl #(
   parameter ss_pkg::bus_id_t TxnId = '0
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   // Host command port
   input  logic                 cmd_req_i,
   input  ss_pkg::cmd_req_t     cmd_i,
   output logic                 cmd_ack_o,
   output ss_pkg::cmd_rsp_t     cmd_rsp_o,
   // Entropy
   input  logic                 rng_valid_i,
   input  ss_pkg::narrow_data_t rng_word_i,
   output logic                 rng_take_o,
   // Narrow bus
   output logic                 nb_valid_o,
   output ss_pkg::narrow_req_t  nb_req_o,
   input  logic                 nb_ready_i,
   input  logic                 rsp_valid_i,
   input  ss_pkg::narrow_rsp_t  rsp_i,
   output logic                 rsp_ready_o
);

   import ss_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      WAIT_RNG,
      ISSUE,
      WAIT_RSP,
      ACK,
      RELEASE
   } state_e;

   state_e      state_q;
   state_e      state_d;
   cmd_op_t     op_q;
   narrow_req_t nb_req_q;
   cmd_rsp_t    cmd_rsp_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (cmd_req_i) begin
               state_d = (cmd_i.op == CMD_WRITE_RANDOM) ? WAIT_RNG : ISSUE;
            end
         end
         WAIT_RNG: begin
            if (rng_valid_i) state_d = ISSUE;
         end
         ISSUE: begin
            if (nb_ready_i) state_d = WAIT_RSP;
         end
         WAIT_RSP: begin
            if (rsp_valid_i) state_d = ACK;
         end
         // Hold ack until the host lets go of req
         ACK: begin
            if (!cmd_req_i) state_d = RELEASE;
         end
         RELEASE: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && cmd_req_i) begin
         op_q           <= cmd_i.op;
         nb_req_q.we    <= (cmd_i.op != CMD_READ);
         nb_req_q.addr  <= cmd_i.addr;
         nb_req_q.wdata <= cmd_i.wdata;
         nb_req_q.id    <= TxnId;
      end
      if (state_q == WAIT_RNG && rng_valid_i) begin
         nb_req_q.wdata <= rng_word_i;
      end
      if (state_q == WAIT_RSP && rsp_valid_i) begin
         cmd_rsp_q.resp <= rsp_i.resp;
         case (op_q)
            CMD_READ:         cmd_rsp_q.rdata <= rsp_i.rdata;
            // Host learns the value that was written
            CMD_WRITE_RANDOM: cmd_rsp_q.rdata <= nb_req_q.wdata;
            default:          cmd_rsp_q.rdata <= '0;
         endcase
      end
   end

   assign cmd_ack_o   = (state_q == ACK);
   assign cmd_rsp_o   = cmd_rsp_q;
   assign rng_take_o  = (state_q == WAIT_RNG) && rng_valid_i;
   assign nb_valid_o  = (state_q == ISSUE);
   assign nb_req_o    = nb_req_q;
   assign rsp_ready_o = (state_q == WAIT_RSP);

   // Host keeps the command steady while req is up
   a_cmd_stable: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (cmd_req_i && $past(cmd_req_i)) |-> $stable(cmd_i)
   ) else $error("rot_cmd_ctrl: cmd changed while req was high");

   a_nb_hold: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (nb_valid_o && !nb_ready_i) |=> (nb_valid_o && $stable(nb_req_o))
   ) else $error("rot_cmd_ctrl: narrow request dropped or changed before ready");

endmodule

//--- design/secure_subsystem.sv
// Top level of the secure subsystem, ties controller, entropy and upsizer and exposes flat bus ports
`timescale 1ns/100ps

module secure_subsystem #(
   parameter ss_pkg::narrow_data_t RngSeed = ss_pkg::LfsrSeedDefault
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   // Host command port
   input  logic                 cmd_req_i,
   input  ss_pkg::cmd_req_t     cmd_i,
   output logic                 cmd_ack_o,
   output ss_pkg::cmd_rsp_t     cmd_rsp_o,
   // AW channel
   output ss_pkg::bus_id_t      aw_id_o,
   output ss_pkg::narrow_addr_t aw_addr_o,
   output logic                 aw_valid_o,
   input  logic                 aw_ready_i,
   // W channel
   output ss_pkg::wide_data_t   w_data_o,
   output ss_pkg::wide_strb_t   w_strb_o,
   output logic                 w_last_o,
   output logic                 w_valid_o,
   input  logic                 w_ready_i,
   // B channel
   input  ss_pkg::bus_id_t      b_id_i,
   input  ss_pkg::resp_t        b_resp_i,
   input  logic                 b_valid_i,
   output logic                 b_ready_o,
   // AR channel
   output ss_pkg::bus_id_t      ar_id_o,
   output ss_pkg::narrow_addr_t ar_addr_o,
   output logic                 ar_valid_o,
   input  logic                 ar_ready_i,
   // R channel
   input  ss_pkg::bus_id_t      r_id_i,
   input  ss_pkg::wide_data_t   r_data_i,
   input  ss_pkg::resp_t        r_resp_i,
   input  logic                 r_last_i,
   input  logic                 r_valid_i,
   output logic                 r_ready_o
);

   import ss_pkg::*;

   localparam bus_id_t TxnId = bus_id_t'(4'h3);

   logic         rng_valid;
   logic         rng_take;
   narrow_data_t rng_word;

   logic         nb_valid;
   logic         nb_ready;
   narrow_req_t  nb_req;
   logic         rsp_valid;
   logic         rsp_ready;
   narrow_rsp_t  rsp;

   ax_chan_t     aw;
   ax_chan_t     ar;
   w_chan_t      w;
   b_chan_t      b;
   r_chan_t      r;

   // Flatten the wide bus
   assign aw_id_o   = aw.id;
   assign aw_addr_o = aw.addr;
   assign w_data_o  = w.data;
   assign w_strb_o  = w.strb;
   assign w_last_o  = w.last;
   assign ar_id_o   = ar.id;
   assign ar_addr_o = ar.addr;

   assign b = '{id: b_id_i, resp: b_resp_i};
   assign r = '{id: r_id_i, data: r_data_i, resp: r_resp_i, last: r_last_i};

   entropy_rng #(
      .RngSeed     ( RngSeed   )
   ) u_rng (
      .clk_i       ( clk_i     ),
      .arst_n_i    ( arst_n_i  ),
      .rng_take_i  ( rng_take  ),
      .rng_valid_o ( rng_valid ),
      .rng_word_o  ( rng_word  )
   );

   rot_cmd_ctrl #(
      .TxnId       ( TxnId     )
   ) u_rot (
      .clk_i       ( clk_i     ),
      .arst_n_i    ( arst_n_i  ),
      .cmd_req_i   ( cmd_req_i ),
      .cmd_i       ( cmd_i     ),
      .cmd_ack_o   ( cmd_ack_o ),
      .cmd_rsp_o   ( cmd_rsp_o ),
      .rng_valid_i ( rng_valid ),
      .rng_word_i  ( rng_word  ),
      .rng_take_o  ( rng_take  ),
      .nb_valid_o  ( nb_valid  ),
      .nb_req_o    ( nb_req    ),
      .nb_ready_i  ( nb_ready  ),
      .rsp_valid_i ( rsp_valid ),
      .rsp_i       ( rsp       ),
      .rsp_ready_o ( rsp_ready )
   );

   axi_dw_upsizer u_dw (
      .clk_i       ( clk_i      ),
      .arst_n_i    ( arst_n_i   ),
      .nb_valid_i  ( nb_valid   ),
      .nb_req_i    ( nb_req     ),
      .nb_ready_o  ( nb_ready   ),
      .rsp_valid_o ( rsp_valid  ),
      .rsp_o       ( rsp        ),
      .rsp_ready_i ( rsp_ready  ),
      .aw_o        ( aw         ),
      .aw_valid_o  ( aw_valid_o ),
      .aw_ready_i  ( aw_ready_i ),
      .w_o         ( w          ),
      .w_valid_o   ( w_valid_o  ),
      .w_ready_i   ( w_ready_i  ),
      .b_i         ( b          ),
      .b_valid_i   ( b_valid_i  ),
      .b_ready_o   ( b_ready_o  ),
      .ar_o        ( ar         ),
      .ar_valid_o  ( ar_valid_o ),
      .ar_ready_i  ( ar_ready_i ),
      .r_i         ( r          ),
      .r_valid_i   ( r_valid_i  ),
      .r_ready_o   ( r_ready_o  )
   );

endmodule

//--- design/ss_pkg.sv
// Shared widths, types, command encoding and bus structs, imported by every block of the subsystem
package ss_pkg;

   parameter int unsigned AddrWidth       = 32;
   parameter int unsigned NarrowDataWidth = 32;
   parameter int unsigned WideDataWidth   = 64;
   parameter int unsigned WideStrbWidth   = WideDataWidth / 8;
   parameter int unsigned BusIdWidth      = 4;

   typedef logic [AddrWidth-1:0]       narrow_addr_t;
   typedef logic [NarrowDataWidth-1:0] narrow_data_t;
   typedef logic [WideDataWidth-1:0]   wide_data_t;
   typedef logic [WideStrbWidth-1:0]   wide_strb_t;
   typedef logic [BusIdWidth-1:0]      bus_id_t;
   typedef logic [1:0]                 resp_t;

   parameter resp_t RESP_OKAY   = 2'b00;
   parameter resp_t RESP_SLVERR = 2'b10;

   // Galois taps for x^32+x^22+x^2+x+1, right-shifting form
   parameter narrow_data_t LfsrTaps        = 32'h8020_0003;
   parameter narrow_data_t LfsrSeedDefault = 32'h0000_0001 ^ 32'h9E37_79B9;

   typedef enum logic [1:0] {
      CMD_READ         = 2'd0,
      CMD_WRITE        = 2'd1,
      CMD_WRITE_RANDOM = 2'd2
   } cmd_op_t;

   // Host command port
   typedef struct packed {
      cmd_op_t      op;
      narrow_addr_t addr;
      narrow_data_t wdata;
   } cmd_req_t;

   typedef struct packed {
      narrow_data_t rdata;
      resp_t        resp;
   } cmd_rsp_t;

   // Narrow single-word bus between controller and upsizer
   typedef struct packed {
      logic         we;
      narrow_addr_t addr;
      narrow_data_t wdata;
      bus_id_t      id;
   } narrow_req_t;

   typedef struct packed {
      narrow_data_t rdata;
      resp_t        resp;
   } narrow_rsp_t;

   // Wide bus channels, one beat per transfer; AW and AR share a layout
   typedef struct packed {
      bus_id_t      id;
      narrow_addr_t addr;
   } ax_chan_t;

   typedef struct packed {
      wide_data_t data;
      wide_strb_t strb;
      logic       last;
   } w_chan_t;

   typedef struct packed {
      bus_id_t id;
      resp_t   resp;
   } b_chan_t;

   typedef struct packed {
      bus_id_t    id;
      wide_data_t data;
      resp_t      resp;
      logic       last;
   } r_chan_t;

endpackage

//--- verification/tb_secure_subsystem.sv
// Testbench that runs a command table through the host port against a wide memory model
`timescale 1ns/100ps

module tb_secure_subsystem;

   import ss_pkg::*;

   localparam narrow_data_t RngSeed  = 32'h1357_9BDF;
   localparam int unsigned  Timeout  = 200;
   // x^32+x^22+x^2+x+1 seen from the right-shifting side is bits 31, 21, 1 and 0
   localparam narrow_data_t TapMask  = 32'h8020_0003;

   typedef struct packed {
      cmd_op_t      op;
      narrow_addr_t addr;
      narrow_data_t wdata;
      narrow_data_t exp_rdata;
      resp_t        exp_resp;
   } step_t;

   logic         clk;
   logic         arst_n;
   logic         cmd_req;
   cmd_req_t     cmd;
   logic         cmd_ack;
   cmd_rsp_t     cmd_rsp;
   bus_id_t      aw_id;
   bus_id_t      b_id;
   bus_id_t      ar_id;
   bus_id_t      r_id;
   narrow_addr_t aw_addr;
   narrow_addr_t ar_addr;
   wide_data_t   w_data;
   wide_data_t   r_data;
   wide_strb_t   w_strb;
   resp_t        b_resp;
   resp_t        r_resp;
   logic         aw_valid;
   logic         aw_ready;
   logic         w_valid;
   logic         w_ready;
   logic         w_last;
   logic         b_valid;
   logic         b_ready;
   logic         ar_valid;
   logic         ar_ready;
   logic         r_valid;
   logic         r_ready;
   logic         r_last;
   step_t        steps [$];

   always #5 clk = ~clk;

   secure_subsystem #(
      .RngSeed    ( RngSeed  )
   ) u_secure_subsystem (
      .clk_i      ( clk      ),
      .arst_n_i   ( arst_n   ),
      .cmd_req_i  ( cmd_req  ),
      .cmd_i      ( cmd      ),
      .cmd_ack_o  ( cmd_ack  ),
      .cmd_rsp_o  ( cmd_rsp  ),
      .aw_id_o    ( aw_id    ),
      .aw_addr_o  ( aw_addr  ),
      .aw_valid_o ( aw_valid ),
      .aw_ready_i ( aw_ready ),
      .w_data_o   ( w_data   ),
      .w_strb_o   ( w_strb   ),
      .w_last_o   ( w_last   ),
      .w_valid_o  ( w_valid  ),
      .w_ready_i  ( w_ready  ),
      .b_id_i     ( b_id     ),
      .b_resp_i   ( b_resp   ),
      .b_valid_i  ( b_valid  ),
      .b_ready_o  ( b_ready  ),
      .ar_id_o    ( ar_id    ),
      .ar_addr_o  ( ar_addr  ),
      .ar_valid_o ( ar_valid ),
      .ar_ready_i ( ar_ready ),
      .r_id_i     ( r_id     ),
      .r_data_i   ( r_data   ),
      .r_resp_i   ( r_resp   ),
      .r_last_i   ( r_last   ),
      .r_valid_i  ( r_valid  ),
      .r_ready_o  ( r_ready  )
   );

   wide_mem_model u_mem (
      .clk_i      ( clk      ),
      .arst_n_i   ( arst_n   ),
      .aw_id_i    ( aw_id    ),
      .aw_addr_i  ( aw_addr  ),
      .aw_valid_i ( aw_valid ),
      .aw_ready_o ( aw_ready ),
      .w_data_i   ( w_data   ),
      .w_strb_i   ( w_strb   ),
      .w_valid_i  ( w_valid  ),
      .w_ready_o  ( w_ready  ),
      .b_id_o     ( b_id     ),
      .b_resp_o   ( b_resp   ),
      .b_valid_o  ( b_valid  ),
      .b_ready_i  ( b_ready  ),
      .ar_id_i    ( ar_id    ),
      .ar_addr_i  ( ar_addr  ),
      .ar_valid_i ( ar_valid ),
      .ar_ready_o ( ar_ready ),
      .r_id_o     ( r_id     ),
      .r_data_o   ( r_data   ),
      .r_resp_o   ( r_resp   ),
      .r_last_o   ( r_last   ),
      .r_valid_o  ( r_valid  ),
      .r_ready_i  ( r_ready  )
   );

   function automatic narrow_data_t lfsr_step(input narrow_data_t state);
      narrow_data_t shifted;
      shifted = state >> 1;
      if (state[0]) shifted = shifted ^ TapMask;
      return shifted;
   endfunction

   task automatic fail_run();
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
         fail_run();
      end
   endtask

   task automatic wait_ack(input logic level, input string what);
      int unsigned cycles;
      cycles = 0;
      while (cmd_ack !== level) begin
         @(negedge clk);
         cycles++;
         if (cycles > Timeout) begin
            $display("Timed out after %0d cycles waiting for %s at %0t", Timeout, what, $time);
            fail_run();
         end
      end
   endtask

   task automatic add_step(input cmd_op_t op, input narrow_addr_t addr, input narrow_data_t wdata,
                           input narrow_data_t exp_rdata, input resp_t exp_resp);
      step_t s;
      s = '{op: op, addr: addr, wdata: wdata, exp_rdata: exp_rdata, exp_resp: exp_resp};
      steps.push_back(s);
   endtask

   task automatic build_table();
      narrow_data_t word;
      narrow_data_t rnd [3];
      int           k;
      // Two words sharing one 64-bit beat
      add_step(CMD_WRITE, 32'h0000_1000, 32'h1111_1111, '0, RESP_OKAY);
      add_step(CMD_WRITE, 32'h0000_1004, 32'h2222_2222, '0, RESP_OKAY);
      add_step(CMD_READ, 32'h0000_1000, '0, 32'h1111_1111, RESP_OKAY);
      add_step(CMD_READ, 32'h0000_1004, '0, 32'h2222_2222, RESP_OKAY);
      // First random word is the seed itself
      word = RngSeed;
      for (k = 0; k < 3; k++) begin
         rnd[k] = word;
         word = lfsr_step(word);
         add_step(CMD_WRITE_RANDOM, 32'h0000_2000 + 4 * k, '0, rnd[k], RESP_OKAY);
      end
      for (k = 0; k < 3; k++) begin
         add_step(CMD_READ, 32'h0000_2000 + 4 * k, '0, rnd[k], RESP_OKAY);
      end
      // Bit 31 is the error window
      add_step(CMD_WRITE, 32'h8000_1000, 32'hDEAD_BEEF, '0, RESP_SLVERR);
      add_step(CMD_READ, 32'h8000_1000, '0, '0, RESP_SLVERR);
      add_step(CMD_READ, 32'h0000_1000, '0, 32'h1111_1111, RESP_OKAY);
   endtask

   task automatic run_step(input int idx);
      step_t s;
      s = steps[idx];
      cmd.op    = s.op;
      cmd.addr  = s.addr;
      cmd.wdata = s.wdata;
      cmd_req   = 1'b1;
      wait_ack(1'b1, "cmd_ack_o to rise");
      check_value($sformatf("step %0d cmd_rsp_o.rdata", idx), s.exp_rdata, cmd_rsp.rdata);
      check_value($sformatf("step %0d cmd_rsp_o.resp", idx), 32'(s.exp_resp), 32'(cmd_rsp.resp));
      // Ack has to hold while req is still up
      repeat (2) begin
         @(negedge clk);
         check_value($sformatf("step %0d cmd_ack_o", idx), 32'd1, 32'(cmd_ack));
      end
      cmd_req = 1'b0;
      wait_ack(1'b0, "cmd_ack_o to fall");
   endtask

   // Every write beat is a single, last beat
   always @(negedge clk) begin
      if (arst_n && w_valid) begin
         check_value("w_last_o", 32'd1, 32'(w_last));
      end
   end

   initial begin
      void'($urandom(32'h5373_fc05));
      clk     = 1'b0;
      arst_n  = 1'b0;
      cmd_req = 1'b0;
      cmd     = '0;
      build_table();
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_value("cmd_ack_o", 32'd0, 32'(cmd_ack));
      check_value("aw_valid_o", 32'd0, 32'(aw_valid));
      check_value("w_valid_o", 32'd0, 32'(w_valid));
      check_value("ar_valid_o", 32'd0, 32'(ar_valid));
      check_value("b_ready_o", 32'd0, 32'(b_ready));
      check_value("r_ready_o", 32'd0, 32'(r_ready));
      for (int i = 0; i < steps.size(); i++) begin
         run_step(i);
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- verification/wide_mem_model.sv
// Wide-bus memory slave for the testbench, sparse 64-bit storage with strobes, an error window and random ready delays
`timescale 1ns/100ps

module wide_mem_model (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  ss_pkg::bus_id_t      aw_id_i,
   input  ss_pkg::narrow_addr_t aw_addr_i,
   input  logic                 aw_valid_i,
   output logic                 aw_ready_o,
   input  ss_pkg::wide_data_t   w_data_i,
   input  ss_pkg::wide_strb_t   w_strb_i,
   input  logic                 w_valid_i,
   output logic                 w_ready_o,
   output ss_pkg::bus_id_t      b_id_o,
   output ss_pkg::resp_t        b_resp_o,
   output logic                 b_valid_o,
   input  logic                 b_ready_i,
   input  ss_pkg::bus_id_t      ar_id_i,
   input  ss_pkg::narrow_addr_t ar_addr_i,
   input  logic                 ar_valid_i,
   output logic                 ar_ready_o,
   output ss_pkg::bus_id_t      r_id_o,
   output ss_pkg::wide_data_t   r_data_o,
   output ss_pkg::resp_t        r_resp_o,
   output logic                 r_last_o,
   output logic                 r_valid_o,
   input  logic                 r_ready_i
);

   import ss_pkg::*;

   wide_data_t   mem [logic [28:0]];
   logic         aw_got;
   logic         w_got;
   narrow_addr_t aw_addr_q;
   bus_id_t      aw_id_q;
   wide_data_t   w_data_q;
   wide_strb_t   w_strb_q;
   int unsigned  aw_dly;
   int unsigned  w_dly;
   int unsigned  ar_dly;

   // Unwritten words read back a pattern built from their address
   function automatic wide_data_t load_word(input narrow_addr_t addr);
      narrow_addr_t base;
      base = {addr[31:3], 3'b000};
      if (mem.exists(addr[31:3])) begin
         return mem[addr[31:3]];
      end
      return {~base, base};
   endfunction

   always @(posedge clk_i or negedge arst_n_i) begin : slave_seq
      wide_data_t word;
      if (!arst_n_i) begin
         aw_ready_o <= 1'b0;
         w_ready_o  <= 1'b0;
         ar_ready_o <= 1'b0;
         b_valid_o  <= 1'b0;
         r_valid_o  <= 1'b0;
         aw_got     <= 1'b0;
         w_got      <= 1'b0;
         aw_dly     <= 0;
         w_dly      <= 0;
         ar_dly     <= 0;
         b_id_o     <= '0;
         b_resp_o   <= RESP_OKAY;
         r_id_o     <= '0;
         r_data_o   <= '0;
         r_resp_o   <= RESP_OKAY;
         r_last_o   <= 1'b0;
      end else begin
         if (aw_valid_i && aw_ready_o) begin
            aw_ready_o <= 1'b0;
            aw_got     <= 1'b1;
            aw_addr_q  <= aw_addr_i;
            aw_id_q    <= aw_id_i;
            aw_dly     <= $urandom_range(3, 0);
         end else if (aw_valid_i && !aw_got) begin
            if (aw_dly == 0) aw_ready_o <= 1'b1;
            else aw_dly <= aw_dly - 1;
         end
         if (w_valid_i && w_ready_o) begin
            w_ready_o <= 1'b0;
            w_got     <= 1'b1;
            w_data_q  <= w_data_i;
            w_strb_q  <= w_strb_i;
            w_dly     <= $urandom_range(3, 0);
         end else if (w_valid_i && !w_got) begin
            if (w_dly == 0) w_ready_o <= 1'b1;
            else w_dly <= w_dly - 1;
         end
         // Both halves of the write are in, commit and answer
         if (aw_got && w_got && !b_valid_o) begin
            if (!aw_addr_q[31]) begin
               word = load_word(aw_addr_q);
               for (int i = 0; i < WideStrbWidth; i++) begin
                  if (w_strb_q[i]) word[8*i +: 8] = w_data_q[8*i +: 8];
               end
               mem[aw_addr_q[31:3]] = word;
            end
            b_id_o    <= aw_id_q;
            b_resp_o  <= aw_addr_q[31] ? RESP_SLVERR : RESP_OKAY;
            b_valid_o <= 1'b1;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
         end else if (b_valid_o && b_ready_i) begin
            b_valid_o <= 1'b0;
         end
         if (ar_valid_i && ar_ready_o) begin
            ar_ready_o <= 1'b0;
            ar_dly     <= $urandom_range(3, 0);
            r_id_o     <= ar_id_i;
            r_last_o   <= 1'b1;
            r_resp_o   <= ar_addr_i[31] ? RESP_SLVERR : RESP_OKAY;
            r_data_o   <= ar_addr_i[31] ? '0 : load_word(ar_addr_i);
            r_valid_o  <= 1'b1;
         end else if (ar_valid_i) begin
            if (ar_dly == 0) ar_ready_o <= 1'b1;
            else ar_dly <= ar_dly - 1;
         end
         if (r_valid_o && r_ready_i) r_valid_o <= 1'b0;
      end
   end

endmodule

//--- verilog.f
design/ss_pkg.sv
design/entropy_rng.sv
design/rot_cmd_ctrl.sv
design/axi_dw_upsizer.sv
design/secure_subsystem.sv
verification/wide_mem_model.sv
verification/tb_secure_subsystem.sv
